/* design/soc_pkg.sv */
`default_nettype none

package soc_pkg;

  // ----------------------------------------
  // Widths and sizes
  // ----------------------------------------
  localparam int unsigned AddrWidth         = 32;
  localparam int unsigned DataWidth         = 32;
  localparam int unsigned BeWidth           = 4;
  localparam int unsigned NumSramBanks      = 2;
  localparam int unsigned SramBankNumWords  = 256;
  localparam int unsigned SramBankAddrWidth = 8;
  localparam int unsigned BlockAddrWidth    = 21;

  // ----------------------------------------
  // Address map and constants
  // ----------------------------------------
  localparam logic [AddrWidth-1:0] SramBaseAddr    = 32'h1000_0000;
  localparam logic [AddrWidth-1:0] SramBankBytes   = 32'h0000_0400;
  localparam logic [AddrWidth-1:0] SocCtrlBaseAddr = 32'h0300_0000;
  localparam logic [AddrWidth-1:0] SocCtrlBytes    = 32'h0000_0010;
  localparam logic [DataWidth-1:0] ErrRspData      = 32'hBADC_AB1E;
  localparam logic [AddrWidth-1:0] BootAddrDefault = SramBaseAddr;
  localparam logic [DataWidth-1:0] SocIdValue      = 32'h0C0C_2024;

  // Word index of each control register
  localparam logic [1:0] CtrlRegBootAddr = 2'd0;
  localparam logic [1:0] CtrlRegFetchEn  = 2'd1;
  localparam logic [1:0] CtrlRegScratch  = 2'd2;
  localparam logic [1:0] CtrlRegSocId    = 2'd3;

  // ----------------------------------------
  // Bus types
  // ----------------------------------------
  typedef struct packed {
    logic                 req;
    logic [AddrWidth-1:0] addr;
    logic                 we;
    logic [BeWidth-1:0]   be;
    logic [DataWidth-1:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic                 gnt;
    logic                 rvalid;
    logic [DataWidth-1:0] rdata;
    logic                 err;
  } obi_rsp_t;

  // Router target with bank entries equal to the bank index
  typedef enum logic [1:0] {
    TgtBank0 = 2'd0,
    TgtBank1 = 2'd1,
    TgtCtrl  = 2'd2,
    TgtErr   = 2'd3
  } target_e;

  // Replace only the byte lanes selected by be
  function automatic logic [DataWidth-1:0] be_merge(
    input logic [DataWidth-1:0] old_data,
    input logic [DataWidth-1:0] wdata,
    input logic [BeWidth-1:0]   be
  );
    logic [DataWidth-1:0] merged;
    merged = old_data;
    for (int b = 0; b < BeWidth; b++) begin
      if (be[b]) begin
        merged[b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

/* design/req_blocker.sv */
`timescale 1ns/1ps
`default_nettype none

module req_blocker import soc_pkg::*; (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  obi_req_t                  in_req_i,
  output obi_rsp_t                  in_rsp_o,
  output obi_req_t                  out_req_o,
  input  obi_rsp_t                  out_rsp_i,
  input  logic                      block_i,
  output logic [BlockAddrWidth-1:0] req_addr_o,
  output logic                      valid_o
);

  logic                      reported_q;
  logic [BlockAddrWidth-1:0] req_addr_q;
  logic [BlockAddrWidth-1:0] word_addr;
  logic                      stalled;

  assign word_addr = in_req_i.addr[BlockAddrWidth+1:2];
  assign stalled   = in_req_i.req & block_i;

  // Mask req while blocked so the router never sees or grants it
  always_comb begin
    out_req_o     = in_req_i;
    out_req_o.req = in_req_i.req & ~block_i;
  end

  assign in_rsp_o = out_rsp_i;

  // One strobe per stalled request
  assign valid_o    = stalled & ~reported_q;
  assign req_addr_o = valid_o ? word_addr : req_addr_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      reported_q <= 1'b0;
      req_addr_q <= '0;
    end else if (valid_o) begin
      reported_q <= 1'b1;
      req_addr_q <= word_addr;
    end else if (in_req_i.req && out_rsp_i.gnt) begin
      // Stalled request finally went through
      reported_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* design/bus_router.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_router import soc_pkg::*; (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  obi_req_t                    mgr_req_i,
  output obi_rsp_t                    mgr_rsp_o,
  output obi_req_t [NumSramBanks-1:0] bank_req_o,
  input  obi_rsp_t [NumSramBanks-1:0] bank_rsp_i,
  output obi_req_t                    ctrl_req_o,
  input  obi_rsp_t                    ctrl_rsp_i
);

  target_e              tgt;
  target_e              rsp_tgt_q;
  logic [AddrWidth-1:0] sram_off;
  logic [AddrWidth-1:0] ctrl_off;
  logic                 gnt;
  logic                 accept;
  logic                 err_valid_q;
  obi_rsp_t             sel_rsp;

  // ----------------------------------------
  // Address decode
  // ----------------------------------------
  // Below a base the offset wraps to a large value and fails the range test
  assign sram_off = mgr_req_i.addr - SramBaseAddr;
  assign ctrl_off = mgr_req_i.addr - SocCtrlBaseAddr;

  always_comb begin
    if (sram_off < NumSramBanks * SramBankBytes) begin
      tgt = (sram_off < SramBankBytes) ? TgtBank0 : TgtBank1;
    end else if (ctrl_off < SocCtrlBytes) begin
      tgt = TgtCtrl;
    end else begin
      tgt = TgtErr;
    end
  end

  // Only the addressed target sees req
  always_comb begin
    for (int i = 0; i < NumSramBanks; i++) begin
      bank_req_o[i]     = mgr_req_i;
      bank_req_o[i].req = mgr_req_i.req && (tgt == target_e'(i));
    end
    ctrl_req_o     = mgr_req_i;
    ctrl_req_o.req = mgr_req_i.req && (tgt == TgtCtrl);
  end

  always_comb begin
    case (tgt)
      TgtBank0: gnt = bank_rsp_i[0].gnt;
      TgtBank1: gnt = bank_rsp_i[1].gnt;
      TgtCtrl:  gnt = ctrl_rsp_i.gnt;
      default:  gnt = mgr_req_i.req;
    endcase
  end

  assign accept = mgr_req_i.req & gnt;

  // ----------------------------------------
  // Response path
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_tgt_q   <= TgtErr;
      err_valid_q <= 1'b0;
    end else begin
      err_valid_q <= accept && (tgt == TgtErr);
      if (accept) begin
        rsp_tgt_q <= tgt;
      end
    end
  end

  // Error subordinate answers every access with ErrRspData and err
  always_comb begin
    case (rsp_tgt_q)
      TgtBank0: sel_rsp = bank_rsp_i[0];
      TgtBank1: sel_rsp = bank_rsp_i[1];
      TgtCtrl:  sel_rsp = ctrl_rsp_i;
      default: begin
        sel_rsp.gnt    = 1'b0;
        sel_rsp.rvalid = err_valid_q;
        sel_rsp.rdata  = ErrRspData;
        sel_rsp.err    = 1'b1;
      end
    endcase
    mgr_rsp_o     = sel_rsp;
    mgr_rsp_o.gnt = gnt;
  end

endmodule

`default_nettype wire

/* design/sram_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_bank import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  obi_req_t req_i,
  output obi_rsp_t rsp_o
);

  logic [DataWidth-1:0]         mem_q [SramBankNumWords];
  logic [SramBankAddrWidth-1:0] word_addr;
  logic [DataWidth-1:0]         rdata_q;
  logic                         rvalid_q;

  assign word_addr = req_i.addr[SramBankAddrWidth+1:2];

  // Storage and read data
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.we) begin
        mem_q[word_addr] <= be_merge(mem_q[word_addr], req_i.wdata, req_i.be);
        rdata_q          <= '0;
      end else begin
        rdata_q <= mem_q[word_addr];
      end
    end
  end

  // Response valid one cycle after each grant
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  // Always ready
  always_comb begin
    rsp_o.gnt    = req_i.req;
    rsp_o.rvalid = rvalid_q;
    rsp_o.rdata  = rdata_q;
    rsp_o.err    = 1'b0;
  end

endmodule

`default_nettype wire

/* design/soc_ctrl_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_ctrl_regs import soc_pkg::*; (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  obi_req_t             req_i,
  output obi_rsp_t             rsp_o,
  input  logic                 fetch_en_i,
  output logic [AddrWidth-1:0] boot_addr_o,
  output logic                 fetch_enable_o
);

  logic [1:0]           reg_idx;
  logic                 wr_en;
  logic [AddrWidth-1:0] boot_addr_q;
  logic                 fetchen_q;
  logic [DataWidth-1:0] scratch_q;
  logic [DataWidth-1:0] rdata_d;
  logic [DataWidth-1:0] rdata_q;
  logic                 rvalid_q;
  logic                 err_q;

  assign reg_idx = req_i.addr[3:2];
  assign wr_en   = req_i.req & req_i.we;

  // Read mux
  always_comb begin
    case (reg_idx)
      CtrlRegBootAddr: rdata_d = boot_addr_q;
      CtrlRegFetchEn:  rdata_d = {{(DataWidth-1){1'b0}}, fetchen_q};
      CtrlRegScratch:  rdata_d = scratch_q;
      default:         rdata_d = SocIdValue;
    endcase
  end

  // ----------------------------------------
  // Register writes
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      boot_addr_q <= BootAddrDefault;
      fetchen_q   <= 1'b0;
      scratch_q   <= '0;
    end else if (wr_en) begin
      case (reg_idx)
        CtrlRegBootAddr: boot_addr_q <= be_merge(boot_addr_q, req_i.wdata, req_i.be);
        CtrlRegFetchEn: begin
          if (req_i.be[0]) begin
            fetchen_q <= req_i.wdata[0];
          end
        end
        CtrlRegScratch:  scratch_q <= be_merge(scratch_q, req_i.wdata, req_i.be);
        default: ;  // ID word is read only
      endcase
    end
  end

  // ----------------------------------------
  // Response
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
      err_q    <= wr_en && (reg_idx == CtrlRegSocId);
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= req_i.we ? '0 : rdata_d;
    end
  end

  always_comb begin
    rsp_o.gnt    = req_i.req;
    rsp_o.rvalid = rvalid_q;
    rsp_o.rdata  = rdata_q;
    rsp_o.err    = err_q;
  end

  assign boot_addr_o    = boot_addr_q;
  assign fetch_enable_o = fetchen_q | fetch_en_i;

endmodule

`default_nettype wire

/* design/mem_domain_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_domain_top import soc_pkg::*; (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  obi_req_t                  req_i,
  output obi_rsp_t                  rsp_o,
  input  logic                      block_i,
  output logic [BlockAddrWidth-1:0] req_addr_o,
  output logic                      valid_o,
  input  logic                      fetch_en_i,
  output logic [AddrWidth-1:0]      boot_addr_o,
  output logic                      fetch_enable_o
);

  // Blocker to router
  obi_req_t blk_req;
  obi_rsp_t blk_rsp;

  // Router to subordinates
  obi_req_t [NumSramBanks-1:0] bank_req;
  obi_rsp_t [NumSramBanks-1:0] bank_rsp;
  obi_req_t                    ctrl_req;
  obi_rsp_t                    ctrl_rsp;

  req_blocker i_req_blocker (
    .clk_i,
    .reset_i,
    .in_req_i   ( req_i      ),
    .in_rsp_o   ( rsp_o      ),
    .out_req_o  ( blk_req    ),
    .out_rsp_i  ( blk_rsp    ),
    .block_i    ( block_i    ),
    .req_addr_o ( req_addr_o ),
    .valid_o    ( valid_o    )
  );

  bus_router i_bus_router (
    .clk_i,
    .reset_i,
    .mgr_req_i  ( blk_req  ),
    .mgr_rsp_o  ( blk_rsp  ),
    .bank_req_o ( bank_req ),
    .bank_rsp_i ( bank_rsp ),
    .ctrl_req_o ( ctrl_req ),
    .ctrl_rsp_i ( ctrl_rsp )
  );

  // ----------------------------------------
  // Memories
  // ----------------------------------------
  for (genvar i = 0; i < NumSramBanks; i++) begin : gen_sram_bank
    sram_bank i_sram_bank (
      .clk_i,
      .reset_i,
      .req_i ( bank_req[i] ),
      .rsp_o ( bank_rsp[i] )
    );
  end

  soc_ctrl_regs i_soc_ctrl_regs (
    .clk_i,
    .reset_i,
    .req_i          ( ctrl_req       ),
    .rsp_o          ( ctrl_rsp       ),
    .fetch_en_i     ( fetch_en_i     ),
    .boot_addr_o    ( boot_addr_o    ),
    .fetch_enable_o ( fetch_enable_o )
  );

endmodule

`default_nettype wire

/* verif/mem_domain_props.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_domain_props import soc_pkg::*; (
  input logic     clk_i,
  input logic     reset_i,
  input obi_req_t req_i,
  input obi_rsp_t rsp_i,
  input logic     block_i,
  input logic     valid_i
);

  logic accept;

  assign accept = req_i.req & rsp_i.gnt;

  // Response exactly one cycle after each acceptance and never otherwise
  a_rvalid_timing : assert property (
    @(posedge clk_i) disable iff (reset_i) rsp_i.rvalid == $past(accept)
  ) else $error("rvalid does not follow an accepted request by one cycle");

  a_no_gnt_blocked : assert property (
    @(posedge clk_i) disable iff (reset_i) block_i |-> !rsp_i.gnt
  ) else $error("gnt high while block_i is high");

  // Block-swap strobe is a single pulse
  a_valid_pulse : assert property (
    @(posedge clk_i) disable iff (reset_i) valid_i |=> !valid_i
  ) else $error("valid_o high in two consecutive cycles");

endmodule

`default_nettype wire

/* verif/mem_domain_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_domain_tb import soc_pkg::*; ();

  localparam int    ClkPeriod     = 8;
  localparam int    ResetCycles   = 2;
  localparam int    SlackCycles   = 4;
  localparam int    PreludeCycles = 16;
  localparam string CaseFile      = "verif/bus_cases.txt";

  // One line of the case file
  typedef struct packed {
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
    logic [BeWidth-1:0]   be;
    logic [7:0]           blk;
    logic [DataWidth-1:0] rdata;
    logic                 err;
  } bus_case_t;

  logic                      clk;
  logic                      reset;
  obi_req_t                  bus_req;
  obi_rsp_t                  bus_rsp;
  logic                      block;
  logic [BlockAddrWidth-1:0] blk_addr;
  logic                      blk_valid;
  logic                      fetch_en;
  logic [AddrWidth-1:0]      boot_addr;
  logic                      fetch_enable;

  // Reference state
  bus_case_t                 cases[$];
  bus_case_t                 pend_case;
  logic                      pend_valid;
  logic                      granted;
  logic                      pulse_seen;
  logic [BlockAddrWidth-1:0] blk_addr_model;
  logic [AddrWidth-1:0]      boot_addr_model;
  logic                      fetchen_model;
  bit                        cases_loaded;
  int unsigned               checks;
  int unsigned               errors;

  mem_domain_top UUT (
    .clk_i          ( clk          ),
    .reset_i        ( reset        ),
    .req_i          ( bus_req      ),
    .rsp_o          ( bus_rsp      ),
    .block_i        ( block        ),
    .req_addr_o     ( blk_addr     ),
    .valid_o        ( blk_valid    ),
    .fetch_en_i     ( fetch_en     ),
    .boot_addr_o    ( boot_addr    ),
    .fetch_enable_o ( fetch_enable )
  );

  bind mem_domain_top mem_domain_props i_props (
    .clk_i   ( clk_i   ),
    .reset_i ( reset_i ),
    .req_i   ( req_i   ),
    .rsp_i   ( rsp_o   ),
    .block_i ( block_i ),
    .valid_i ( valid_o )
  );

  initial clk = 1'b0;
  always #(ClkPeriod / 2) clk = ~clk;

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic compare_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("CHECK FAILED %s expected %h actual %h at %0t", name, exp, act, $time);
      errors++;
    end
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  task automatic load_cases();
    int                   fd;
    int                   n;
    string                line;
    logic                 we;
    logic                 err;
    logic [BeWidth-1:0]   be;
    logic [7:0]           blk;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
    logic [DataWidth-1:0] rdata;
    fd = $fopen(CaseFile, "r");
    if (fd == 0) begin
      $display("Could not open the case file %s", CaseFile);
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h", we, addr, wdata, be, blk, rdata, err);
          if (n == 7) begin
            cases.push_back('{we, addr, wdata, be, blk, rdata, err});
          end
        end
      end
      $fclose(fd);
    end
    cases_loaded = 1'b1;
  endtask

  // Checks last cycle's response, drives the next inputs, then checks the same-cycle outputs
  task automatic run_cycle(input bus_case_t c, input logic active, input logic blk,
                           input logic fe);
    logic exp_pulse;
    @(negedge clk);
    compare_word("rvalid", 32'(pend_valid), 32'(bus_rsp.rvalid));
    if (pend_valid) begin
      compare_word("rdata", pend_case.rdata, bus_rsp.rdata);
      compare_word("err", 32'(pend_case.err), 32'(bus_rsp.err));
    end
    compare_word("boot_addr_o", boot_addr_model, boot_addr);
    compare_word("fetch_enable_o", 32'(fetchen_model | fetch_en), 32'(fetch_enable));
    bus_req.req   = active;
    bus_req.addr  = c.addr;
    bus_req.we    = c.we;
    bus_req.be    = c.be;
    bus_req.wdata = c.wdata;
    block         = blk;
    fetch_en      = fe;
    #1;
    compare_word("gnt", 32'(active & ~blk), 32'(bus_rsp.gnt));
    exp_pulse = active & blk & ~pulse_seen;
    compare_word("valid_o", 32'(exp_pulse), 32'(blk_valid));
    if (exp_pulse) begin
      blk_addr_model = c.addr[22:2];
      pulse_seen     = 1'b1;
    end
    compare_word("req_addr_o", 32'(blk_addr_model), 32'(blk_addr));
    granted    = active & bus_rsp.gnt;
    pend_valid = granted;
    pend_case  = c;
    if (granted) begin
      pulse_seen = 1'b0;
      // Control registers seen on the top-level outputs
      if (c.we && c.addr == SocCtrlBaseAddr) begin
        boot_addr_model = merge_bytes(boot_addr_model, c.wdata, c.be);
      end
      if (c.we && c.addr == SocCtrlBaseAddr + 32'd4 && c.be[0]) begin
        fetchen_model = c.wdata[0];
      end
    end
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin : main
    bus_case_t idle;
    idle            = '0;
    reset           = 1'b1;
    block           = 1'b0;
    fetch_en        = 1'b0;
    bus_req         = '0;
    pend_case       = '0;
    pend_valid      = 1'b0;
    granted         = 1'b0;
    pulse_seen      = 1'b0;
    blk_addr_model  = '0;
    boot_addr_model = BootAddrDefault;
    fetchen_model   = 1'b0;
    checks          = 0;
    errors          = 0;
    load_cases();
    repeat (ResetCycles) @(negedge clk);
    reset = 1'b0;
    // fetch_en_i on its own
    run_cycle(idle, 1'b0, 1'b0, 1'b0);
    run_cycle(idle, 1'b0, 1'b0, 1'b1);
    run_cycle(idle, 1'b0, 1'b0, 1'b1);
    run_cycle(idle, 1'b0, 1'b0, 1'b0);
    foreach (cases[i]) begin
      for (int k = 0; k < int'(cases[i].blk); k++) begin
        run_cycle(cases[i], 1'b1, 1'b1, 1'b0);
      end
      do begin
        run_cycle(cases[i], 1'b1, 1'b0, 1'b0);
      end while (!granted);
    end
    run_cycle(idle, 1'b0, 1'b0, 1'b0);
    run_cycle(idle, 1'b0, 1'b0, 1'b0);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin : watchdog
    int max_blk;
    int limit;
    max_blk = 0;
    wait (cases_loaded);
    foreach (cases[i]) begin
      if (int'(cases[i].blk) > max_blk) begin
        max_blk = int'(cases[i].blk);
      end
    end
    limit = (cases.size() * (max_blk + SlackCycles) + PreludeCycles) * ClkPeriod;
    #(limit);
    $display("Timeout after %0d ns, a request was never granted", limit);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/bus_cases.txt */
# One bus transaction per line, all fields hex
# we addr wdata be block_cycles exp_rdata exp_err
0 03000000 00000000 f 0 10000000 0
0 03000004 00000000 f 0 00000000 0
0 0300000c 00000000 f 0 0c0c2024 0
1 10000010 11223344 f 0 00000000 0
1 10000010 aabbccdd 5 0 00000000 0
0 10000010 00000000 f 0 11bb33dd 0
1 10000400 55667788 f 0 00000000 0
1 10000400 00ee0000 4 0 00000000 0
0 10000400 00000000 f 0 55ee7788 0
1 100007fc deadbeef f 0 00000000 0
1 100007fc 1234cafe 3 0 00000000 0
0 100007fc 00000000 f 0 deadcafe 0
0 00000000 00000000 f 0 badcab1e 1
1 10000800 12345678 f 0 badcab1e 1
0 03000010 00000000 f 0 badcab1e 1
1 0300000c ffffffff f 0 00000000 1
0 0300000c 00000000 f 0 0c0c2024 0
1 03000008 a5a5a5a5 f 0 00000000 0
1 03000008 0000005a 1 0 00000000 0
0 03000008 00000000 f 0 a5a5a55a 0
1 03000004 00000001 1 0 00000000 0
0 03000004 00000000 f 0 00000001 0
1 03000000 10000400 f 0 00000000 0
0 03000000 00000000 f 0 10000400 0
0 10000400 00000000 f 3 55ee7788 0
1 10000004 cafef00d f 5 00000000 0
0 10000004 00000000 f 1 cafef00d 0
0 0300000c 00000000 f 2 0c0c2024 0
0 10000010 00000000 f 0 11bb33dd 0
0 100007fc 00000000 f 0 deadcafe 0
0 10000004 00000000 f 0 cafef00d 0
0 10000400 00000000 f 0 55ee7788 0

/* list.f */
design/soc_pkg.sv
design/req_blocker.sv
design/bus_router.sv
design/sram_bank.sv
design/soc_ctrl_regs.sv
design/mem_domain_top.sv
verif/mem_domain_props.sv
verif/mem_domain_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the memory domain testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module mem_domain_tb -f list.f -o sim_mem_domain
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_mem_domain +verilator+error+limit+100)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Testbench passed" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi
